//--- hdl/dma_pkg.sv
package dma_pkg;

   // datapath
   localparam int DATA_W   = 32;
   localparam int BYTES    = DATA_W / 8;
   localparam int OFFSET_W = $clog2(BYTES);

   // addressing, byte address in and word address out
   localparam int ADDR_W  = 16;
   localparam int WADDR_W = ADDR_W - OFFSET_W;

   // transfer sizing
   localparam int LEN_W     = 8;
   localparam int BURST_LEN = 4; // max words per burst

   // register map
   localparam int REG_AW = 2;

   localparam logic [REG_AW-1:0] REG_SRC  = 2'd0;
   localparam logic [REG_AW-1:0] REG_LEN  = 2'd1;
   localparam logic [REG_AW-1:0] REG_CTRL = 2'd2;

endpackage

//--- hdl/dma_regs.sv
module dma_regs (
   input  logic                        clk_i,
   input  logic                        rst_i,
   input  logic                        reg_we_i,
   input  logic [dma_pkg::REG_AW-1:0]  reg_addr_i,
   input  logic [dma_pkg::DATA_W-1:0]  reg_wdata_i,
   output logic [dma_pkg::DATA_W-1:0]  reg_rdata_o,
   input  logic                        busy_i,
   output logic                        start_o,
   output logic [dma_pkg::ADDR_W-1:0]  src_addr_o,
   output logic [dma_pkg::LEN_W-1:0]   len_o
);
   import dma_pkg::*;

   logic [ADDR_W-1:0] src_q;
   logic [LEN_W-1:0]  len_q;
   logic              start_q;
   logic              start_req;

   // a start is only taken from idle with something to move
   assign start_req = reg_we_i && (reg_addr_i == REG_CTRL) && !busy_i && (len_q != '0);

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         src_q   <= '0;
         len_q   <= '0;
         start_q <= 1'b0;
      end else begin
         start_q <= start_req; // single cycle pulse
         if (reg_we_i) begin
            case (reg_addr_i)
               REG_SRC: src_q <= reg_wdata_i[ADDR_W-1:0];
               REG_LEN: len_q <= reg_wdata_i[LEN_W-1:0];
               default: ;
            endcase
         end
      end
   end

   // read mux
   always_comb begin
      reg_rdata_o = '0;
      case (reg_addr_i)
         REG_SRC:  reg_rdata_o[ADDR_W-1:0] = src_q;
         REG_LEN:  reg_rdata_o[LEN_W-1:0]  = len_q;
         REG_CTRL: reg_rdata_o[0]          = busy_i;
         default:  reg_rdata_o = '0;
      endcase
   end

   assign start_o    = start_q;
   assign src_addr_o = src_q;
   assign len_o      = len_q;

endmodule

//--- hdl/dma_read_ctrl.sv
module dma_read_ctrl (
   input  logic                        clk_i,
   input  logic                        rst_i,
   input  logic                        start_i,
   input  logic [dma_pkg::ADDR_W-1:0]  src_addr_i,
   input  logic [dma_pkg::LEN_W-1:0]   len_i,
   output logic                        mem_req_o,
   output logic [dma_pkg::WADDR_W-1:0] mem_addr_o,
   input  logic                        mem_rvalid_i,
   output logic                        burst_last_o,
   output logic                        transfer_last_o,
   output logic                        busy_o
);
   import dma_pkg::*;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_ISSUE,
      ST_WAIT
   } state_t;

   state_t            state_q;
   logic [WADDR_W-1:0] waddr_q;
   logic [LEN_W-1:0]  req_left_q;  // words not yet requested
   logic [LEN_W-1:0]  iss_left_q;  // requests left in this burst
   logic [LEN_W-1:0]  ret_burst_q; // returns pending in this burst
   logic [LEN_W-1:0]  ret_total_q; // returns pending in the transfer

   function automatic logic [LEN_W-1:0] burst_size(input logic [LEN_W-1:0] n);
      logic [LEN_W-1:0] max_len;
      max_len = LEN_W'(BURST_LEN);
      return (n > max_len) ? max_len : n;
   endfunction

   assign mem_req_o       = (state_q == ST_ISSUE);
   assign mem_addr_o      = waddr_q;
   assign burst_last_o    = mem_rvalid_i && (ret_burst_q == LEN_W'(1));
   assign transfer_last_o = mem_rvalid_i && (ret_total_q == LEN_W'(1));

   // drops on the final return, so the flush cycle already reads idle
   assign busy_o = (state_q != ST_IDLE) || start_i;

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         state_q     <= ST_IDLE;
         req_left_q  <= '0;
         iss_left_q  <= '0;
         ret_burst_q <= '0;
         ret_total_q <= '0;
      end else begin
         if (mem_rvalid_i) begin
            ret_burst_q <= ret_burst_q - 1'b1;
            ret_total_q <= ret_total_q - 1'b1;
         end

         case (state_q)
            ST_IDLE: begin
               if (start_i) begin
                  req_left_q  <= len_i;
                  ret_total_q <= len_i;
                  iss_left_q  <= burst_size(len_i);
                  ret_burst_q <= burst_size(len_i);
                  state_q     <= ST_ISSUE;
               end
            end
            ST_ISSUE: begin
               req_left_q <= req_left_q - 1'b1;
               iss_left_q <= iss_left_q - 1'b1;
               if (iss_left_q == LEN_W'(1))
                  state_q <= ST_WAIT;
            end
            ST_WAIT: begin
               if (transfer_last_o) begin
                  state_q <= ST_IDLE;
               end else if (burst_last_o) begin
                  // next burst starts right after the last return
                  iss_left_q  <= burst_size(req_left_q);
                  ret_burst_q <= burst_size(req_left_q);
                  state_q     <= ST_ISSUE;
               end
            end
            default: state_q <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (start_i && state_q == ST_IDLE)
         waddr_q <= src_addr_i[ADDR_W-1:OFFSET_W];
      else if (mem_req_o)
         waddr_q <= waddr_q + 1'b1;
   end

endmodule

//--- hdl/burst_align.sv
module burst_align (
   input  logic                         clk_i,
   input  logic                         rst_i,
   input  logic [dma_pkg::OFFSET_W-1:0] offset_i,
   input  logic                         start_i,
   input  logic                         burst_last_i,
   input  logic                         transfer_last_i,
   input  logic [dma_pkg::DATA_W-1:0]   data_in_i,
   input  logic                         valid_in_i,
   output logic [dma_pkg::DATA_W-1:0]   data_out_o,
   output logic                         valid_out_o,
   output logic                         last_transfer_o
);
   import dma_pkg::*;

   logic [OFFSET_W-1:0] offset_q;
   logic                primed_q;  // store holds a word of this transfer
   logic                flush_q;
   logic [DATA_W-1:0]   stored_q;
   logic [DATA_W-1:0]   in_word;
   logic [2*DATA_W-1:0] joined;

   // flush pads with zeros past the fetched region
   assign in_word = flush_q ? '0 : data_in_i;

   always_comb begin
      joined     = {in_word, stored_q} >> {offset_q, 3'b000};
      data_out_o = joined[DATA_W-1:0];
   end

   assign valid_out_o     = (primed_q && valid_in_i) || flush_q;
   assign last_transfer_o = flush_q;

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         offset_q <= '0;
         primed_q <= 1'b0;
         flush_q  <= 1'b0;
      end else begin
         flush_q <= burst_last_i && transfer_last_i;
         if (start_i) begin
            offset_q <= offset_i; // held for the whole transfer
            primed_q <= 1'b0;
         end
         if (valid_in_i)
            primed_q <= 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (valid_in_i)
         stored_q <= data_in_i;
   end

endmodule

//--- hdl/dma_align_top.sv
module dma_align_top (
   input  logic                        clk_i,
   input  logic                        rst_i,
   input  logic                        reg_we_i,
   input  logic [dma_pkg::REG_AW-1:0]  reg_addr_i,
   input  logic [dma_pkg::DATA_W-1:0]  reg_wdata_i,
   output logic [dma_pkg::DATA_W-1:0]  reg_rdata_o,
   output logic                        mem_req_o,
   output logic [dma_pkg::WADDR_W-1:0] mem_addr_o,
   input  logic                        mem_rvalid_i,
   input  logic [dma_pkg::DATA_W-1:0]  mem_rdata_i,
   output logic                        out_valid_o,
   output logic [dma_pkg::DATA_W-1:0]  out_data_o,
   output logic                        out_last_o
);
   import dma_pkg::*;

   logic              busy;
   logic              start;
   logic [ADDR_W-1:0] src_addr;
   logic [LEN_W-1:0]  len;
   logic              burst_last;
   logic              transfer_last;

   dma_regs u_regs (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .reg_we_i    (reg_we_i),
      .reg_addr_i  (reg_addr_i),
      .reg_wdata_i (reg_wdata_i),
      .reg_rdata_o (reg_rdata_o),
      .busy_i      (busy),
      .start_o     (start),
      .src_addr_o  (src_addr),
      .len_o       (len)
   );

   dma_read_ctrl u_read_ctrl (
      .clk_i           (clk_i),
      .rst_i           (rst_i),
      .start_i         (start),
      .src_addr_i      (src_addr),
      .len_i           (len),
      .mem_req_o       (mem_req_o),
      .mem_addr_o      (mem_addr_o),
      .mem_rvalid_i    (mem_rvalid_i),
      .burst_last_o    (burst_last),
      .transfer_last_o (transfer_last),
      .busy_o          (busy)
   );

   burst_align u_align (
      .clk_i           (clk_i),
      .rst_i           (rst_i),
      .offset_i        (src_addr[OFFSET_W-1:0]),
      .start_i         (start),
      .burst_last_i    (burst_last),
      .transfer_last_i (transfer_last),
      .data_in_i       (mem_rdata_i),
      .valid_in_i      (mem_rvalid_i),
      .data_out_o      (out_data_o),
      .valid_out_o     (out_valid_o),
      .last_transfer_o (out_last_o)
   );

endmodule

//--- verification/mem_model.sv
module mem_model (
   input  logic                        clk_i,
   input  logic                        rst_i,
   input  logic                        req_i,
   input  logic [dma_pkg::WADDR_W-1:0] addr_i,
   output logic                        rvalid_o,
   output logic [dma_pkg::DATA_W-1:0]  rdata_o
);
   timeunit 1ns;
   timeprecision 100ps;
   import dma_pkg::*;

   logic [WADDR_W-1:0] addr_q[$];
   int                 due_q[$];   // cycle at which each return goes out
   int                 cycle;
   int                 last_due;
   int unsigned        lcg_state;

   function automatic int unsigned lcg_next(input int unsigned s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   // byte j of word w is the low byte of (4w+j) xor 0x5a
   function automatic logic [DATA_W-1:0] word_at(input logic [WADDR_W-1:0] w);
      logic [DATA_W-1:0] d;
      logic [ADDR_W-1:0] a;
      int                j;
      d = '0;
      for (j = 0; j < BYTES; j++) begin
         a = {w, OFFSET_W'(j)};
         d[8*j +: 8] = a[7:0] ^ 8'h5A;
      end
      return d;
   endfunction

   always @(posedge clk_i or posedge rst_i) begin
      int lat;
      int due;
      if (rst_i) begin
         addr_q.delete();
         due_q.delete();
         cycle     = 0;
         last_due  = 0;
         lcg_state = 151;
         rvalid_o <= 1'b0;
         rdata_o  <= '0;
      end else begin
         cycle = cycle + 1;
         if (req_i) begin
            lcg_state = lcg_next(lcg_state);
            lat = 1 + int'((lcg_state >> 16) % 4); // 1 to 4 cycles
            due = cycle + lat - 1;
            if (due <= last_due)
               due = last_due + 1; // keeps returns in order, one per cycle
            last_due = due;
            addr_q.push_back(addr_i);
            due_q.push_back(due);
         end
         if (due_q.size() > 0 && due_q[0] <= cycle) begin
            rvalid_o <= 1'b1;
            rdata_o  <= word_at(addr_q.pop_front());
            void'(due_q.pop_front());
         end else begin
            rvalid_o <= 1'b0;
         end
      end
   end

endmodule

//--- verification/tb_dma_align.sv
module tb_dma_align;
   timeunit 1ns;
   timeprecision 100ps;
   import dma_pkg::*;

   localparam int TIMEOUT     = 200;
   localparam int IDLE_CYCLES = 12;
   localparam int N_ROWS      = 7;

   typedef struct packed {
      logic [ADDR_W-1:0] src;
      logic [LEN_W-1:0]  len;
      logic              accept;
      logic              poke;   // second CTRL write while busy
   } row_t;

   logic                clk;
   logic                rst;
   logic                reg_we;
   logic [REG_AW-1:0]   reg_addr;
   logic [DATA_W-1:0]   reg_wdata;
   logic [DATA_W-1:0]   reg_rdata;
   logic                mem_req;
   logic [WADDR_W-1:0]  mem_addr;
   logic                mem_rvalid;
   logic [DATA_W-1:0]   mem_rdata;
   logic                out_valid;
   logic [DATA_W-1:0]   out_data;
   logic                out_last;

   row_t                rows[N_ROWS];
   logic [DATA_W-1:0]   out_data_q[$];
   logic                out_last_q[$];
   logic [WADDR_W-1:0]  req_addr_q[$];
   int                  outstanding = 0;
   int                  burst_reqs = 0;
   int                  last_count = 0;
   int                  mismatches = 0;
   int                  failures = 0;
   bit                  timed_out = 1'b0;

   dma_align_top u_dma_align_top (
      .clk_i        (clk),
      .rst_i        (rst),
      .reg_we_i     (reg_we),
      .reg_addr_i   (reg_addr),
      .reg_wdata_i  (reg_wdata),
      .reg_rdata_o  (reg_rdata),
      .mem_req_o    (mem_req),
      .mem_addr_o   (mem_addr),
      .mem_rvalid_i (mem_rvalid),
      .mem_rdata_i  (mem_rdata),
      .out_valid_o  (out_valid),
      .out_data_o   (out_data),
      .out_last_o   (out_last)
   );

   mem_model u_mem (
      .clk_i    (clk),
      .rst_i    (rst),
      .req_i    (mem_req),
      .addr_i   (mem_addr),
      .rvalid_o (mem_rvalid),
      .rdata_o  (mem_rdata)
   );

   initial clk = 1'b0;
   always #10 clk = ~clk;

   // sampled mid cycle, away from the driving edge
   always @(negedge clk) begin
      if (!rst) begin
         if (mem_req) begin
            req_addr_q.push_back(mem_addr);
            // new burst only once every earlier return is back
            burst_reqs = (outstanding == 0) ? 1 : burst_reqs + 1;
            if (burst_reqs == BURST_LEN + 1) begin
               failures++;
               $display("ERROR: more than %0d requests issued in one burst", BURST_LEN);
            end
            outstanding++;
         end
         if (mem_rvalid)
            outstanding--;
         if (out_valid) begin
            out_data_q.push_back(out_data);
            out_last_q.push_back(out_last);
         end
         if (out_last)
            last_count++;
      end
   end

   function automatic logic [7:0] model_byte(input int a);
      return 8'(a) ^ 8'h5A;
   endfunction

   // bytes past the last fetched word read as zero
   function automatic logic [DATA_W-1:0] predict_word(input int src, input int len, input int k);
      logic [DATA_W-1:0] w;
      int                a;
      int                limit;
      int                j;
      w     = '0;
      limit = 4 * ((src / 4) + len);
      for (j = 0; j < BYTES; j++) begin
         a = src + 4 * k + j;
         if (a < limit)
            w[8*j +: 8] = model_byte(a);
      end
      return w;
   endfunction

   task automatic check_data(input string name, input logic [DATA_W-1:0] got,
                             input logic [DATA_W-1:0] exp);
      if (got !== exp) begin
         mismatches++;
         $display("MISMATCH %0d ns %s: got %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_addr(input string name, input logic [WADDR_W-1:0] got,
                             input logic [WADDR_W-1:0] exp);
      if (got !== exp) begin
         mismatches++;
         $display("MISMATCH %0d ns %s: got %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         mismatches++;
         $display("MISMATCH %0d ns %s: got %b, expected %b", $time, name, got, exp);
      end
   endtask

   task automatic check_count(input string name, input int got, input int exp);
      if (got != exp) begin
         mismatches++;
         $display("MISMATCH %0d ns %s: got %0d, expected %0d", $time, name, got, exp);
      end
   endtask

   task automatic reg_write(input logic [REG_AW-1:0] addr, input logic [DATA_W-1:0] data);
      @(posedge clk);
      reg_we    <= 1'b1;
      reg_addr  <= addr;
      reg_wdata <= data;
      @(posedge clk);
      reg_we    <= 1'b0;
   endtask

   task automatic reg_read(input logic [REG_AW-1:0] addr, output logic [DATA_W-1:0] data);
      @(posedge clk);
      reg_addr <= addr;
      @(negedge clk);
      data = reg_rdata;
   endtask

   task automatic wait_busy();
      logic [DATA_W-1:0] rd;
      int                cycles;
      rd     = '0;
      cycles = 0;
      while (rd[0] !== 1'b1 && cycles < TIMEOUT) begin
         reg_read(REG_CTRL, rd);
         cycles++;
      end
      if (rd[0] !== 1'b1) begin
         failures++;
         timed_out = 1'b1;
         $display("ERROR: busy never read 1 after the start command");
      end
   endtask

   task automatic wait_last(input int start_cnt);
      int cycles;
      cycles = 0;
      while (last_count == start_cnt && cycles < TIMEOUT) begin
         @(posedge clk);
         cycles++;
      end
      if (last_count == start_cnt) begin
         failures++;
         timed_out = 1'b1;
         $display("ERROR: transfer did not end within %0d cycles", TIMEOUT);
      end
   endtask

   task automatic apply_row(input row_t r);
      logic [DATA_W-1:0]  rd;
      logic [ADDR_W-1:0]  new_src;
      logic [WADDR_W-1:0] exp_addr;
      int                 last_start;
      int                 cycles;
      int                 n;
      int                 k;
      out_data_q.delete();
      out_last_q.delete();
      req_addr_q.delete();
      last_start      = last_count;
      new_src         = r.src + 16'h1001;
      reg_write(REG_SRC, DATA_W'(r.src));
      reg_write(REG_LEN, DATA_W'(r.len));
      reg_write(REG_CTRL, 32'd1);
      if (!r.accept) begin
         cycles = 0;
         while (req_addr_q.size() == 0 && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
         end
         check_count("mem_req_o count", req_addr_q.size(), 0);
         check_count("out_valid_o count", out_data_q.size(), 0);
         reg_read(REG_CTRL, rd);
         check_bit("busy", rd[0], 1'b0);
         return;
      end
      wait_busy();
      if (timed_out)
         return;
      if (r.poke) begin
         reg_write(REG_SRC, DATA_W'(new_src));
         reg_write(REG_CTRL, 32'd1); // must be dropped, engine busy
         reg_read(REG_SRC, rd);
         check_data("reg_rdata_o REG_SRC", rd, DATA_W'(new_src));
      end
      wait_last(last_start);
      if (timed_out)
         return;
      repeat (IDLE_CYCLES) @(posedge clk);
      check_count("out_valid_o count", out_data_q.size(), int'(r.len));
      check_count("mem_req_o count", req_addr_q.size(), int'(r.len));
      check_count("out_last_o count", last_count - last_start, 1);
      n = (out_data_q.size() < int'(r.len)) ? out_data_q.size() : int'(r.len);
      for (k = 0; k < n; k++) begin
         check_data("out_data_o", out_data_q[k], predict_word(int'(r.src), int'(r.len), k));
         check_bit("out_last_o", out_last_q[k], k == int'(r.len) - 1);
      end
      n = (req_addr_q.size() < int'(r.len)) ? req_addr_q.size() : int'(r.len);
      for (k = 0; k < n; k++) begin
         exp_addr = WADDR_W'(int'(r.src) / 4 + k);
         check_addr("mem_addr_o", req_addr_q[k], exp_addr);
      end
      reg_read(REG_CTRL, rd);
      check_bit("busy", rd[0], 1'b0);
   endtask

   initial begin
      logic [DATA_W-1:0] rd;
      int                i;
      rst       = 1'b1;
      reg_we    = 1'b0;
      reg_addr  = '0;
      reg_wdata = '0;
      rows[0] = '{16'h0100, 8'd8, 1'b1, 1'b0}; // aligned
      rows[1] = '{16'h0201, 8'd1, 1'b1, 1'b0};
      rows[2] = '{16'h0302, 8'd5, 1'b1, 1'b0};
      rows[3] = '{16'h0403, 8'd6, 1'b1, 1'b0};
      rows[4] = '{16'h0522, 8'd7, 1'b1, 1'b1};
      rows[5] = '{16'h0600, 8'd0, 1'b0, 1'b0}; // zero length
      rows[6] = '{16'h1FF5, 8'd9, 1'b1, 1'b0};
      repeat (8) @(posedge clk);
      rst <= 1'b0;

      reg_read(REG_SRC, rd);
      check_data("reg_rdata_o REG_SRC", rd, '0);
      reg_read(REG_LEN, rd);
      check_data("reg_rdata_o REG_LEN", rd, '0);
      reg_read(REG_CTRL, rd);
      check_data("reg_rdata_o REG_CTRL", rd, '0);
      repeat (IDLE_CYCLES) @(posedge clk);
      check_count("mem_req_o count", req_addr_q.size(), 0);
      check_count("out_valid_o count", out_data_q.size(), 0);
      check_count("out_last_o count", last_count, 0);

      for (i = 0; i < N_ROWS; i++) begin
         apply_row(rows[i]);
         if (timed_out)
            break;
      end

      $display("%0d mismatches, %0d other errors", mismatches, failures);
      if (mismatches == 0 && failures == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

//--- tb.f
hdl/dma_pkg.sv
hdl/dma_regs.sv
hdl/dma_read_ctrl.sv
hdl/burst_align.sv
hdl/dma_align_top.sv
verification/mem_model.sv
verification/tb_dma_align.sv

//--- Bender.yml
package:
  name: dma_align

sources:
  - hdl/dma_pkg.sv
  - hdl/dma_regs.sv
  - hdl/dma_read_ctrl.sv
  - hdl/burst_align.sv
  - hdl/dma_align_top.sv
  - target: test
    files:
      - verification/mem_model.sv
      - verification/tb_dma_align.sv
